/* compile.f */
+incdir+.
cpu_pkg.sv
opcode_decoder.sv
state_sequencer.sv
strobe_generator.sv
control_unit.sv
tb_clock_gen.sv
control_unit_assert.sv
control_unit_tb.sv

/* control_unit.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module control_unit import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`WORD_WIDTH-1:0] ir,
    input  logic                   con_ff,
    output logic                   read,
    output logic                   ram_write,
    output logic                   hi_enable,
    output logic                   lo_enable,
    output logic                   con_enable,
    output logic                   pc_enable,
    output logic                   ir_enable,
    output logic                   y_enable,
    output logic                   z_enable,
    output logic                   mar_enable,
    output logic                   mdr_enable,
    output logic                   c_sign_extended_out,
    output logic                   ba_out,
    output logic                   gra,
    output logic                   grb,
    output logic                   grc,
    output logic                   r_in,
    output logic                   r_out,
    output logic                   hi_out,
    output logic                   lo_out,
    output logic                   zhi_out,
    output logic                   zlo_out,
    output logic                   mdr_out,
    output logic                   pc_out,
    output logic                   pc_increment,
    output logic                   y_clr,
    output logic                   ir_clr,
    output logic                   r15_enable
);

    instr_class_t instr_class;
    state_t       state;
    logic         phase;

    opcode_decoder opcode_decoder_i (
        .ir          (ir),
        .instr_class (instr_class)
    );

    state_sequencer state_sequencer_i (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .state       (state),
        .phase       (phase)
    );

    strobe_generator strobe_generator_i (
        .state               (state),
        .phase               (phase),
        .con_ff              (con_ff),
        .read                (read),
        .ram_write           (ram_write),
        .hi_enable           (hi_enable),
        .lo_enable           (lo_enable),
        .con_enable          (con_enable),
        .pc_enable           (pc_enable),
        .ir_enable           (ir_enable),
        .y_enable            (y_enable),
        .z_enable            (z_enable),
        .mar_enable          (mar_enable),
        .mdr_enable          (mdr_enable),
        .c_sign_extended_out (c_sign_extended_out),
        .ba_out              (ba_out),
        .gra                 (gra),
        .grb                 (grb),
        .grc                 (grc),
        .r_in                (r_in),
        .r_out               (r_out),
        .hi_out              (hi_out),
        .lo_out              (lo_out),
        .zhi_out             (zhi_out),
        .zlo_out             (zlo_out),
        .mdr_out             (mdr_out),
        .pc_out              (pc_out),
        .pc_increment        (pc_increment),
        .y_clr               (y_clr),
        .ir_clr              (ir_clr),
        .r15_enable          (r15_enable)
    );

endmodule

/* control_unit_assert.sv */
`timescale 1ns/1ps

module control_unit_assert (
    input logic clk,
    input logic reset,
    input logic gra,
    input logic grb,
    input logic grc,
    input logic r_in,
    input logic r_out,
    input logic read,
    input logic ram_write
);

    int fail_count = 0;

    // register file has a single select decoder
    reg_select_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({gra, grb, grc}))
        else begin
            fail_count++;
            $error("more than one of gra, grb, grc high");
        end

    reg_in_out_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(r_in && r_out))
        else begin
            fail_count++;
            $error("r_in and r_out high together");
        end

    mem_read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && ram_write))
        else begin
            fail_count++;
            $error("read and ram_write high together");
        end

endmodule

bind control_unit control_unit_assert control_unit_assert_i (.*);

/* control_unit_tb.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module control_unit_tb import cpu_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;

    // bit positions follow the strobes concatenation below
    localparam logic [27:0]
        m_read       = 28'h1 << 27,
        m_ram_write  = 28'h1 << 26,
        m_hi_enable  = 28'h1 << 25,
        m_lo_enable  = 28'h1 << 24,
        m_con_enable = 28'h1 << 23,
        m_pc_enable  = 28'h1 << 22,
        m_ir_enable  = 28'h1 << 21,
        m_y_enable   = 28'h1 << 20,
        m_z_enable   = 28'h1 << 19,
        m_mar_enable = 28'h1 << 18,
        m_mdr_enable = 28'h1 << 17,
        m_c_sign     = 28'h1 << 16,
        m_ba_out     = 28'h1 << 15,
        m_gra        = 28'h1 << 14,
        m_grb        = 28'h1 << 13,
        m_grc        = 28'h1 << 12,
        m_r_in       = 28'h1 << 11,
        m_r_out      = 28'h1 << 10,
        m_hi_out     = 28'h1 << 9,
        m_lo_out     = 28'h1 << 8,
        m_zhi_out    = 28'h1 << 7,
        m_zlo_out    = 28'h1 << 6,
        m_mdr_out    = 28'h1 << 5,
        m_pc_out     = 28'h1 << 4,
        m_pc_inc     = 28'h1 << 3,
        m_y_clr      = 28'h1 << 2,
        m_ir_clr     = 28'h1 << 1,
        m_r15_enable = 28'h1 << 0;

    localparam logic [27:0] FETCH0_P0 = m_pc_out | m_mar_enable | m_pc_inc | m_ir_clr | m_y_clr;

    logic                   clk;
    logic                   reset;
    logic [`WORD_WIDTH-1:0] ir;
    logic                   con_ff;
    logic read, ram_write, hi_enable, lo_enable, con_enable, pc_enable, ir_enable;
    logic y_enable, z_enable, mar_enable, mdr_enable, c_sign_extended_out, ba_out;
    logic gra, grb, grc, r_in, r_out, hi_out, lo_out, zhi_out, zlo_out, mdr_out;
    logic pc_out, pc_increment, y_clr, ir_clr, r15_enable;
    logic [27:0]            strobes;
    int                     errors = 0;
    int                     cycles = 0;
    int unsigned            seed;

    tb_clock_gen clock_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    control_unit control_unit_i (.*);

    assign strobes = {read, ram_write, hi_enable, lo_enable, con_enable, pc_enable, ir_enable,
                      y_enable, z_enable, mar_enable, mdr_enable, c_sign_extended_out, ba_out,
                      gra, grb, grc, r_in, r_out, hi_out, lo_out, zhi_out, zlo_out, mdr_out,
                      pc_out, pc_increment, y_clr, ir_clr, r15_enable};

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: no end of test after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #2;   // sample and drive just after the edge
    endtask

    task automatic expect_strobes(input string label, input logic [27:0] exp);
        assert (strobes === exp) else begin
            errors++;
            $display("[FAIL] strobes at %s: got %h expected %h", label, strobes, exp);
        end
    endtask

    // phase 0 pattern, then phase 1 all low
    task automatic exec_state(input string label, input logic [27:0] exp);
        expect_strobes(label, exp);
        step();
        expect_strobes({label, " p1"}, '0);
        step();
    endtask

    task automatic skip_state(input string label);
        step();
        expect_strobes({label, " p1"}, '0);
        step();
    endtask

    // called at fetch0 phase 0, returns at the first execute state
    task automatic start_instr(input logic [`OPCODE_WIDTH-1:0] op, input logic con);
        ir = $urandom;
        ir[`OPCODE_MSB:`OPCODE_LSB] = op;
        con_ff = con;
        expect_strobes("fetch0", FETCH0_P0);
        step();
        expect_strobes("fetch0 p1", m_pc_out | m_z_enable);
        step();
        exec_state("fetch1", m_read | m_mdr_enable | m_pc_enable | m_zlo_out);
        exec_state("fetch2", m_mdr_out | m_ir_enable);
    endtask

    task automatic check_length(input string name, input int start, input int len);
        assert (cycles - start == len) else begin
            errors++;
            $display("[FAIL] %s cycles: got %h expected %h", name, cycles - start, len);
        end
        expect_strobes({name, " next fetch0"}, FETCH0_P0);
    endtask

    task automatic test_reset();
        @(negedge clk);
        expect_strobes("reset", '0);
        @(negedge reset);
        #1;
        expect_strobes("st_reset", '0);
        step();
        expect_strobes("st_reset p1", '0);
        step();   // now fetch0
    endtask

    task automatic test_alu();
        int start;
        start = cycles;
        start_instr(op_add, 1'b0);
        exec_state("alu_rr3", m_grb | m_r_out | m_y_enable);
        exec_state("alu_rr4", m_grc | m_r_out | m_z_enable);
        exec_state("alu_rr5", m_zlo_out | m_gra | m_r_in);
        check_length("add", start, 12);
        start = cycles;
        start_instr(op_ori, 1'b1);
        exec_state("alu_imm3", m_grb | m_r_out | m_y_enable);
        exec_state("alu_imm4", m_c_sign | m_z_enable);
        exec_state("alu_imm5", m_zlo_out | m_gra | m_r_in);
        check_length("ori", start, 12);
    endtask

    task automatic test_branch();
        int start;
        for (int c = 0; c < 2; c++) begin
            start = cycles;
            start_instr(op_branch, c[0]);
            exec_state("br3", m_gra | m_r_out | m_con_enable);
            exec_state("br4", m_pc_out | m_y_enable);
            exec_state("br5", m_c_sign | m_z_enable);
            exec_state("br6", m_zlo_out | (c[0] ? m_pc_enable : '0));   // taken on con_ff
            check_length("branch", start, 14);
        end
    endtask

    task automatic test_memory();
        int start;
        start = cycles;
        start_instr(op_ld, 1'b0);
        exec_state("ld3", m_grb | m_ba_out | m_y_enable);
        exec_state("ld4", m_c_sign | m_z_enable);
        exec_state("ld5", m_zlo_out | m_mar_enable);
        exec_state("ld6", m_read | m_mdr_enable);
        exec_state("ld7", m_mdr_out | m_gra | m_r_in);
        check_length("ld", start, 16);
        start = cycles;
        start_instr(op_st, 1'b1);
        skip_state("st3");
        skip_state("st4");
        skip_state("st5");
        skip_state("st6");
        exec_state("st7", m_ram_write);
        check_length("st", start, 16);
        start = cycles;
        start_instr(op_mul, 1'b0);
        skip_state("mul_div3");
        skip_state("mul_div4");
        exec_state("mul_div5", m_zlo_out | m_lo_enable);
        exec_state("mul_div6", m_zhi_out | m_hi_enable);
        check_length("mul", start, 14);
    endtask

    // hi and lo moved into ra
    task automatic test_moves();
        int start;
        start = cycles;
        start_instr(op_mfhi, 1'b0);
        exec_state("mfhi3", m_hi_out | m_gra | m_r_in);
        check_length("mfhi", start, 8);
        start = cycles;
        start_instr(op_mflo, 1'b1);
        exec_state("mflo3", m_lo_out | m_gra | m_r_in);
        check_length("mflo", start, 8);
    endtask

    task automatic test_jumps();
        int start;
        start = cycles;
        start_instr(op_jal, 1'b0);
        exec_state("jal3", m_pc_out | m_r15_enable);
        exec_state("jal4", m_gra | m_r_out | m_pc_enable);
        check_length("jal", start, 10);
        start = cycles;
        start_instr(op_jr, 1'b0);
        exec_state("jr3", m_gra | m_r_out | m_pc_enable);
        check_length("jr", start, 8);
        start = cycles;
        start_instr(op_out, 1'b1);   // out has no states of its own
        exec_state("nop3 (out)", '0);
        check_length("out", start, 8);
        start = cycles;
        start_instr(5'd29, 1'b0);
        exec_state("nop3 (unused)", '0);
        check_length("unused opcode", start, 8);
    endtask

    initial begin
        int assert_errors;
        seed = 32'h66e8_da79;
        void'($urandom(seed));
        ir = '0;
        con_ff = 1'b0;
        test_reset();
        test_alu();
        test_branch();
        test_memory();
        test_moves();
        test_jumps();
        assert_errors = control_unit_i.control_unit_assert_i.fail_count;
        $display("checks: %0d errors, %0d assertion errors", errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// instruction word
`define WORD_WIDTH   32

// opcode field, top five bits
`define OPCODE_MSB   31
`define OPCODE_LSB   27
`define OPCODE_WIDTH 5

// state code width, room for every execute step
`define STATE_WIDTH  6

`endif

/* cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

    // opcode encodings as seen in ir[31:27]
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        op_ld     = 5'b00000,
        op_ldi    = 5'b00001,
        op_st     = 5'b00010,
        op_add    = 5'b00011,
        op_sub    = 5'b00100,
        op_shr    = 5'b00101,
        op_shra   = 5'b00110,
        op_shl    = 5'b00111,
        op_ror    = 5'b01000,
        op_rol    = 5'b01001,
        op_and    = 5'b01010,
        op_or     = 5'b01011,
        op_addi   = 5'b01100,
        op_andi   = 5'b01101,
        op_ori    = 5'b01110,
        op_mul    = 5'b01111,
        op_div    = 5'b10000,
        op_neg    = 5'b10001,
        op_not    = 5'b10010,
        op_branch = 5'b10011,
        op_jr     = 5'b10100,
        op_jal    = 5'b10101,
        op_in     = 5'b10110,
        op_out    = 5'b10111,
        op_mfhi   = 5'b11000,
        op_mflo   = 5'b11001,
        op_nop    = 5'b11010
    } opcode_t;

    // one value per execute sequence
    typedef enum logic [3:0] {
        cls_ld, cls_ldi, cls_st, cls_br,
        cls_alu_rr,   // add, sub, and, or, shifts, rotates
        cls_alu_imm,  // addi, andi, ori
        cls_unary,    // neg, not
        cls_mul_div,
        cls_mfhi, cls_mflo,
        cls_jal, cls_jr,
        cls_nop
    } instr_class_t;

    typedef enum logic [`STATE_WIDTH-1:0] {
        st_reset,
        fetch0, fetch1, fetch2,
        ld3, ld4, ld5, ld6, ld7,
        ldi3, ldi4, ldi5,
        br3, br4, br5, br6,
        nop3,
        alu_rr3, alu_rr4, alu_rr5,
        alu_imm3, alu_imm4, alu_imm5,
        unary3, unary4,
        st3, st4, st5, st6, st7,
        mul_div3, mul_div4, mul_div5, mul_div6,
        mfhi3,
        mflo3,
        jal3, jal4,
        jr3
    } state_t;

endpackage

/* opcode_decoder.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module opcode_decoder import cpu_pkg::*; (
    input  logic [`WORD_WIDTH-1:0] ir,
    output instr_class_t           instr_class
);

    opcode_t opcode;

    assign opcode = opcode_t'(ir[`OPCODE_MSB:`OPCODE_LSB]);

    always_comb begin
        case (opcode)
            op_ld:     instr_class = cls_ld;
            op_ldi:    instr_class = cls_ldi;
            op_st:     instr_class = cls_st;
            op_branch: instr_class = cls_br;
            op_add,
            op_sub,
            op_and,
            op_or,
            op_shr,
            op_shra,
            op_shl,
            op_ror,
            op_rol:    instr_class = cls_alu_rr;   // same y/z/writeback pattern
            op_addi,
            op_andi,
            op_ori:    instr_class = cls_alu_imm;
            op_neg,
            op_not:    instr_class = cls_unary;
            op_mul,
            op_div:    instr_class = cls_mul_div;
            op_mfhi:   instr_class = cls_mfhi;
            op_mflo:   instr_class = cls_mflo;
            op_jal:    instr_class = cls_jal;
            op_jr:     instr_class = cls_jr;
            // in/out have no execute states
            op_in,
            op_out,
            op_nop:    instr_class = cls_nop;
            default:   instr_class = cls_nop;      // codes 27..31
        endcase
    end

endmodule

/* state_sequencer.sv */
`timescale 1ns/1ps

module state_sequencer import cpu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  instr_class_t instr_class,
    output state_t       state,
    output logic         phase
);

    state_t next_state;

    // each state lasts two clocks, phase 0 then phase 1
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_reset;
            phase <= 1'b0;
        end else begin
            phase <= ~phase;
            if (phase) begin
                state <= next_state;   // advance only at end of phase 1
            end
        end
    end

    always_comb begin
        case (state)
            st_reset: next_state = fetch0;
            fetch0:   next_state = fetch1;
            fetch1:   next_state = fetch2;
            // dispatch on the freshly loaded instruction
            fetch2: begin
                case (instr_class)
                    cls_ld:      next_state = ld3;
                    cls_ldi:     next_state = ldi3;
                    cls_st:      next_state = st3;
                    cls_br:      next_state = br3;
                    cls_alu_rr:  next_state = alu_rr3;
                    cls_alu_imm: next_state = alu_imm3;
                    cls_unary:   next_state = unary3;
                    cls_mul_div: next_state = mul_div3;
                    cls_mfhi:    next_state = mfhi3;
                    cls_mflo:    next_state = mflo3;
                    cls_jal:     next_state = jal3;
                    cls_jr:      next_state = jr3;
                    default:     next_state = nop3;
                endcase
            end
            ld3:      next_state = ld4;
            ld4:      next_state = ld5;
            ld5:      next_state = ld6;
            ld6:      next_state = ld7;
            ldi3:     next_state = ldi4;
            ldi4:     next_state = ldi5;
            br3:      next_state = br4;
            br4:      next_state = br5;
            br5:      next_state = br6;
            alu_rr3:  next_state = alu_rr4;
            alu_rr4:  next_state = alu_rr5;
            alu_imm3: next_state = alu_imm4;
            alu_imm4: next_state = alu_imm5;
            unary3:   next_state = unary4;
            st3:      next_state = st4;
            st4:      next_state = st5;
            st5:      next_state = st6;
            st6:      next_state = st7;
            mul_div3: next_state = mul_div4;
            mul_div4: next_state = mul_div5;
            mul_div5: next_state = mul_div6;
            jal3:     next_state = jal4;
            // ld7, ldi5, br6, nop3, alu_rr5, alu_imm5, unary4, st7,
            // mul_div6, mfhi3, mflo3, jal4 and jr3 close the instruction
            default:  next_state = fetch0;
        endcase
    end

endmodule

/* strobe_generator.sv */
`timescale 1ns/1ps

module strobe_generator import cpu_pkg::*; (
    input  state_t state,
    input  logic   phase,
    input  logic   con_ff,
    output logic   read,
    output logic   ram_write,
    output logic   hi_enable,
    output logic   lo_enable,
    output logic   con_enable,
    output logic   pc_enable,
    output logic   ir_enable,
    output logic   y_enable,
    output logic   z_enable,
    output logic   mar_enable,
    output logic   mdr_enable,
    output logic   c_sign_extended_out,
    output logic   ba_out,
    output logic   gra,
    output logic   grb,
    output logic   grc,
    output logic   r_in,
    output logic   r_out,
    output logic   hi_out,
    output logic   lo_out,
    output logic   zhi_out,
    output logic   zlo_out,
    output logic   mdr_out,
    output logic   pc_out,
    output logic   pc_increment,
    output logic   y_clr,
    output logic   ir_clr,
    output logic   r15_enable
);

    always_comb begin
        read                = 1'b0;
        ram_write           = 1'b0;
        hi_enable           = 1'b0;
        lo_enable           = 1'b0;
        con_enable          = 1'b0;
        pc_enable           = 1'b0;
        ir_enable           = 1'b0;
        y_enable            = 1'b0;
        z_enable            = 1'b0;
        mar_enable          = 1'b0;
        mdr_enable          = 1'b0;
        c_sign_extended_out = 1'b0;
        ba_out              = 1'b0;
        gra                 = 1'b0;
        grb                 = 1'b0;
        grc                 = 1'b0;
        r_in                = 1'b0;
        r_out               = 1'b0;
        hi_out              = 1'b0;
        lo_out              = 1'b0;
        zhi_out             = 1'b0;
        zlo_out             = 1'b0;
        mdr_out             = 1'b0;
        pc_out              = 1'b0;
        pc_increment        = 1'b0;
        y_clr               = 1'b0;
        ir_clr              = 1'b0;
        r15_enable          = 1'b0;

        if (state == fetch0) begin
            pc_out = 1'b1;                 // held across both phases
            if (!phase) begin
                mar_enable   = 1'b1;
                pc_increment = 1'b1;
                ir_clr       = 1'b1;
                y_clr        = 1'b1;
            end else begin
                z_enable = 1'b1;           // latch pc + 1
            end
        end else if (!phase) begin
            case (state)
                fetch1: begin
                    read       = 1'b1;
                    mdr_enable = 1'b1;
                    pc_enable  = 1'b1;
                    zlo_out    = 1'b1;
                end
                fetch2: begin
                    mdr_out   = 1'b1;
                    ir_enable = 1'b1;
                end
                // base register into y
                ld3, ldi3, st3: begin
                    if (state == st3) gra = 1'b1;
                    else grb = 1'b1;
                    ba_out   = 1'b1;
                    y_enable = 1'b1;
                end
                // add the sign-extended constant
                ld4, ldi4, st4, br5, alu_imm4: begin
                    c_sign_extended_out = 1'b1;
                    z_enable            = 1'b1;
                end
                ld5, st5: begin
                    zlo_out    = 1'b1;
                    mar_enable = 1'b1;
                end
                ld6: begin
                    read       = 1'b1;
                    mdr_enable = 1'b1;
                end
                ld7: begin
                    mdr_out = 1'b1;
                    gra     = 1'b1;
                    r_in    = 1'b1;
                end
                // result written back to ra
                ldi5, alu_rr5, alu_imm5, unary4: begin
                    zlo_out = 1'b1;
                    gra     = 1'b1;
                    r_in    = 1'b1;
                end
                br3: begin
                    gra        = 1'b1;
                    r_out      = 1'b1;
                    con_enable = 1'b1;
                end
                br4: begin
                    pc_out   = 1'b1;
                    y_enable = 1'b1;
                end
                br6: begin
                    zlo_out   = 1'b1;
                    pc_enable = con_ff;    // taken only when condition holds
                end
                alu_rr3, alu_imm3: begin
                    grb      = 1'b1;
                    r_out    = 1'b1;
                    y_enable = 1'b1;
                end
                alu_rr4: begin
                    grc      = 1'b1;
                    r_out    = 1'b1;
                    z_enable = 1'b1;
                end
                unary3, mul_div4: begin
                    grb      = 1'b1;
                    r_out    = 1'b1;
                    z_enable = 1'b1;
                end
                st6: begin
                    grb        = 1'b1;
                    r_out      = 1'b1;
                    mdr_enable = 1'b1;
                end
                st7: ram_write = 1'b1;
                mul_div3: begin
                    gra      = 1'b1;
                    r_out    = 1'b1;
                    y_enable = 1'b1;
                end
                mul_div5: begin
                    zlo_out   = 1'b1;
                    lo_enable = 1'b1;
                end
                mul_div6: begin
                    zhi_out   = 1'b1;
                    hi_enable = 1'b1;
                end
                mfhi3, mflo3: begin
                    hi_out = (state == mfhi3);
                    lo_out = (state == mflo3);
                    gra    = 1'b1;
                    r_in   = 1'b1;
                end
                jal3: begin
                    pc_out     = 1'b1;     // return address into r15
                    r15_enable = 1'b1;
                end
                jal4, jr3: begin
                    gra       = 1'b1;
                    r_out     = 1'b1;
                    pc_enable = 1'b1;
                end
                default: ;                 // st_reset, nop3
            endcase
        end
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;   // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;   // released off the edge, like the other inputs
    end

endmodule
